// File: hdl/dupPkg.sv
//////////////////////////////////////////////////////////////////////
// DUP11 register block shared definitions
// Host bus width, device register width, register select and
// transmit state encodings, and bit positions of RXCSR, TXCSR and
// PARCSR as fixed by the host architecture
//////////////////////////////////////////////////////////////////////

package dupPkg;

   // Host I/O bus data width
   localparam int dataWidth = 36;
   // Device register width
   localparam int regWidth  = 16;

   // Register selected by the 2-bit word offset
   typedef enum logic [1:0]
   {
      selRxCsr  = 2'd0,
      selRxDbuf = 2'd1,   // PARCSR on write
      selTxCsr  = 2'd2,
      selTxDbuf = 2'd3
   } dupRegSel;

   // Transmit path state
   typedef enum logic
   {
      txIdle = 1'b0,      // Buffer empty
      txFull = 1'b1       // Character offered to the line
   } txState;

   // RXCSR bits
   localparam int rxDoneBit  = 7;
   localparam int rxIeBit    = 6;
   localparam int rxEnBit    = 4;

   // TXCSR bits
   localparam int txDoneBit  = 7;
   localparam int txIeBit    = 6;
   localparam int sendBit    = 4;
   // Device reset, always reads as zero
   localparam int dresetBit  = 8;

   // PARCSR bits, sync character in 7..0
   localparam int decModeBit = 15;
   localparam int ssmBit     = 12;
   localparam int crcInhBit  = 9;

endpackage

// File: hdl/dupParCsr.sv
//////////////////////////////////////////////////////////////////////
// DUP11 parameter register (PARCSR)
// Holds the sync character and the line mode bits, loaded per byte
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dupParCsr
(
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         dupInit,
   input  logic                         parWrite,
   input  logic                         busLoByte,
   input  logic                         busHiByte,
   input  logic [dupPkg::dataWidth-1:0] busData,
   output logic [15:0]                  regParCsr
);

   import dupPkg::*;

   logic       decMode;
   logic       secMode;
   logic       crcInh;
   logic [7:0] syncChar;

   // High byte mode bits
   always_ff @(posedge clk)
   begin
      if (!rstN || dupInit)
      begin
         decMode <= 1'b0;
         secMode <= 1'b0;
         crcInh  <= 1'b0;
      end
      else if (parWrite && busHiByte)
      begin
         decMode <= busData[decModeBit];
         secMode <= busData[ssmBit];
         crcInh  <= busData[crcInhBit];
      end
   end

   // Low byte sync character
   always_ff @(posedge clk)
   begin
      if (!rstN || dupInit)
         syncChar <= 8'h00;
      else if (parWrite && busLoByte)
         syncChar <= busData[7:0];
   end

   // Register image, reserved bits stay zero
   always_comb
   begin
      regParCsr             = '0;
      regParCsr[decModeBit] = decMode;
      regParCsr[ssmBit]     = secMode;
      regParCsr[crcInhBit]  = crcInh;
      regParCsr[7:0]        = syncChar;
   end

endmodule

// File: hdl/dupRxCsr.sv
//////////////////////////////////////////////////////////////////////
// DUP11 receiver status (RXCSR) and data buffer (RXDBUF)
// Accepts characters on the line-side valid/ready handshake and
// holds one until the host reads RXDBUF
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dupRxCsr
(
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         dupInit,
   input  logic                         rxCsrWrite,
   input  logic                         rxDbufRead,
   input  logic                         busLoByte,
   input  logic [dupPkg::dataWidth-1:0] busData,
   input  logic                         rxValid,
   input  logic [7:0]                   rxChar,
   output logic                         rxReady,
   output logic [15:0]                  regRxCsr,
   output logic [15:0]                  regRxDbuf,
   output logic                         rxIntr
);

   import dupPkg::*;

   logic       rxEn;
   logic       rxIe;
   logic       rxDone;
   logic [7:0] rxBuf;
   logic       rxXfer;

   ////////////////////////////////////////////////////////////////////
   // Line-side handshake
   ////////////////////////////////////////////////////////////////////

   // Always ready when disabled, characters just fall on the floor
   assign rxReady = !rxEn || !rxDone;
   assign rxXfer  = rxValid && rxReady;

   // Enables written through the low byte only
   always_ff @(posedge clk)
   begin
      if (!rstN || dupInit)
      begin
         rxEn <= 1'b0;
         rxIe <= 1'b0;
      end
      else if (rxCsrWrite && busLoByte)
      begin
         rxEn <= busData[rxEnBit];
         rxIe <= busData[rxIeBit];
      end
   end

   // Capture and done flag
   always_ff @(posedge clk)
   begin
      if (!rstN || dupInit)
      begin
         rxDone <= 1'b0;
         rxBuf  <= 8'h00;
      end
      else if (rxXfer && rxEn)
      begin
         rxDone <= 1'b1;
         rxBuf  <= rxChar;
      end
      else if (rxDbufRead)
         rxDone <= 1'b0;
   end

   // Register images
   always_comb
   begin
      regRxCsr            = '0;
      regRxCsr[rxDoneBit] = rxDone;
      regRxCsr[rxIeBit]   = rxIe;
      regRxCsr[rxEnBit]   = rxEn;
   end

   assign regRxDbuf = {8'h00, rxBuf};

   // Interrupt request, no added delay
   assign rxIntr = rxDone && rxIe;

   // Held character is never overwritten before the host reads it
   rxHoldCheck: assert property (@(posedge clk) disable iff (!rstN)
      rxDone && rxEn && !dupInit |=> $stable(rxBuf));

endmodule

// File: hdl/dupTxCsr.sv
//////////////////////////////////////////////////////////////////////
// DUP11 transmitter status register (TXCSR)
// Send and interrupt enables, transmit done flag and the one-cycle
// device initialize pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dupTxCsr
(
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         busInit,
   input  logic                         txCsrWrite,
   input  logic                         busLoByte,
   input  logic [dupPkg::dataWidth-1:0] busData,
   input  logic                         txSent,
   input  logic                         txDbufLoad,
   output logic                         dupInit,
   output logic                         sendEn,
   output logic [15:0]                  regTxCsr,
   output logic                         txIntr
);

   import dupPkg::*;

   logic txIe;
   logic txDone;
   logic resetReq;

   // Device reset taken on writes that carry the low byte lane
   assign resetReq = txCsrWrite && busLoByte && busData[dresetBit];

   // Init pulse, a request during the pulse is not stretched
   always_ff @(posedge clk)
   begin
      if (!rstN)
         dupInit <= 1'b0;
      else
         dupInit <= busInit || (resetReq && !dupInit);
   end

   // Enables
   always_ff @(posedge clk)
   begin
      if (!rstN || dupInit)
      begin
         sendEn <= 1'b0;
         txIe   <= 1'b0;
      end
      else if (txCsrWrite && busLoByte)
      begin
         sendEn <= busData[sendBit];
         txIe   <= busData[txIeBit];
      end
   end

   // Done flag, set out of reset as the buffer starts empty
   always_ff @(posedge clk)
   begin
      if (!rstN || dupInit)
         txDone <= 1'b1;
      else if (txDbufLoad)
         txDone <= 1'b0;
      else if (txSent)
         txDone <= 1'b1;
   end

   // Register image, dreset reads back as zero
   always_comb
   begin
      regTxCsr            = '0;
      regTxCsr[txDoneBit] = txDone;
      regTxCsr[txIeBit]   = txIe;
      regTxCsr[sendBit]   = sendEn;
   end

   assign txIntr = txDone && txIe;

   // Pulse is single cycle unless the host holds busInit
   initPulseCheck: assert property (@(posedge clk) disable iff (!rstN)
      dupInit && !busInit |=> !dupInit);

endmodule

// File: hdl/dupTxPath.sv
//////////////////////////////////////////////////////////////////////
// DUP11 transmit data buffer (TXDBUF)
// One-character buffer offered to the line on a valid/ready
// handshake while send is enabled
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dupTxPath
(
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         dupInit,
   input  logic                         txDbufWrite,
   input  logic                         busLoByte,
   input  logic [dupPkg::dataWidth-1:0] busData,
   input  logic                         sendEn,
   output logic                         txValid,
   output logic [7:0]                   txChar,
   output logic                         txSent,
   output logic [15:0]                  regTxDbuf,
   input  logic                         txReady
);

   import dupPkg::*;

   txState state;

   // Offer only while full and send enabled
   assign txValid = (state == txFull) && sendEn;
   assign txSent  = txValid && txReady;

   // FSM, a host write wins over a same-cycle transfer
   always_ff @(posedge clk)
   begin
      if (!rstN || dupInit)
         state <= txIdle;
      else if (txDbufWrite)
         state <= txFull;
      else if (txSent)
         state <= txIdle;
   end

   // Character loaded from the low byte
   always_ff @(posedge clk)
   begin
      if (!rstN || dupInit)
         txChar <= 8'h00;
      else if (txDbufWrite && busLoByte)
         txChar <= busData[7:0];
   end

   assign regTxDbuf = {8'h00, txChar};

   // Offered character holds through line stalls
   txHoldCheck: assert property (@(posedge clk) disable iff (!rstN)
      txValid && !txReady && !txDbufWrite && !dupInit |=> $stable(txChar));

endmodule

// File: hdl/dupBusDecode.sv
//////////////////////////////////////////////////////////////////////
// DUP11 host bus decode
// Word offset to register strobes, registered read data
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dupBusDecode
(
   input  logic                        clk,
   input  logic                        rstN,
   input  logic [1:0]                  busAddr,
   input  logic                        busWrite,
   input  logic                        busRead,
   input  logic [15:0]                 regRxCsr,
   input  logic [15:0]                 regRxDbuf,
   input  logic [15:0]                 regTxCsr,
   input  logic [15:0]                 regTxDbuf,
   output logic                        parWrite,
   output logic                        rxCsrWrite,
   output logic                        txCsrWrite,
   output logic                        txDbufWrite,
   output logic                        rxDbufRead,
   output logic [dupPkg::regWidth-1:0] rdData,
   output logic                        rdValid
);

   import dupPkg::*;

   dupRegSel             regSel;
   logic [regWidth-1:0]  rdMux;

   assign regSel = dupRegSel'(busAddr);

   ////////////////////////////////////////////////////////////////////
   // Strobes
   ////////////////////////////////////////////////////////////////////

   // Offset 1 is PARCSR on write, RXDBUF on read
   assign rxCsrWrite  = busWrite && (regSel == selRxCsr);
   assign parWrite    = busWrite && (regSel == selRxDbuf);
   assign txCsrWrite  = busWrite && (regSel == selTxCsr);
   assign txDbufWrite = busWrite && (regSel == selTxDbuf);
   assign rxDbufRead  = busRead  && (regSel == selRxDbuf);

   ////////////////////////////////////////////////////////////////////
   // Read path
   ////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (regSel)
         selRxCsr:  rdMux = regRxCsr;
         selRxDbuf: rdMux = regRxDbuf;
         selTxCsr:  rdMux = regTxCsr;
         default:   rdMux = regTxDbuf;
      endcase
   end

   // Value as seen at the strobe edge
   always_ff @(posedge clk)
   begin
      if (busRead)
         rdData <= rdMux;
   end

   always_ff @(posedge clk)
   begin
      if (!rstN)
         rdValid <= 1'b0;
      else
         rdValid <= busRead;
   end

   // Host issues one access per cycle
   busExclCheck: assert property (@(posedge clk) disable iff (!rstN)
      !(busRead && busWrite));

endmodule

// File: hdl/dupRegs.sv
//////////////////////////////////////////////////////////////////////
// DUP11 register block top level
// Connects the host bus decode, the four device registers and the
// line-side receive and transmit handshakes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dupRegs
(
   input  logic                         clk,
   input  logic                         rstN,
   // Host bus
   input  logic [1:0]                   busAddr,
   input  logic                         busWrite,
   input  logic                         busRead,
   input  logic                         busLoByte,
   input  logic                         busHiByte,
   input  logic [dupPkg::dataWidth-1:0] busData,
   input  logic                         busInit,
   output logic [dupPkg::regWidth-1:0]  rdData,
   output logic                         rdValid,
   // Interrupt requests
   output logic                         rxIntr,
   output logic                         txIntr,
   // Line side receive
   input  logic                         rxValid,
   input  logic [7:0]                   rxChar,
   output logic                         rxReady,
   // Line side transmit
   output logic                         txValid,
   output logic [7:0]                   txChar,
   input  logic                         txReady,
   // Line settings from PARCSR
   output logic [7:0]                   lineSync,
   output logic                         crcInhibit,
   output logic                         secMode,
   output logic                         decMode
);

   import dupPkg::*;

   logic        parWrite;
   logic        rxCsrWrite;
   logic        txCsrWrite;
   logic        txDbufWrite;
   logic        rxDbufRead;
   logic        dupInit;
   logic        sendEn;
   logic        txSent;
   logic [15:0] regParCsr;
   logic [15:0] regRxCsr;
   logic [15:0] regRxDbuf;
   logic [15:0] regTxCsr;
   logic [15:0] regTxDbuf;

   ////////////////////////////////////////////////////////////////////
   // Bus decode
   ////////////////////////////////////////////////////////////////////

   dupBusDecode busDecode
   (
      .clk         (clk),
      .rstN        (rstN),
      .busAddr     (busAddr),
      .busWrite    (busWrite),
      .busRead     (busRead),
      .regRxCsr    (regRxCsr),
      .regRxDbuf   (regRxDbuf),
      .regTxCsr    (regTxCsr),
      .regTxDbuf   (regTxDbuf),
      .parWrite    (parWrite),
      .rxCsrWrite  (rxCsrWrite),
      .txCsrWrite  (txCsrWrite),
      .txDbufWrite (txDbufWrite),
      .rxDbufRead  (rxDbufRead),
      .rdData      (rdData),
      .rdValid     (rdValid)
   );

   ////////////////////////////////////////////////////////////////////
   // Device registers
   ////////////////////////////////////////////////////////////////////

   dupParCsr parCsr
   (
      .clk       (clk),
      .rstN      (rstN),
      .dupInit   (dupInit),
      .parWrite  (parWrite),
      .busLoByte (busLoByte),
      .busHiByte (busHiByte),
      .busData   (busData),
      .regParCsr (regParCsr)
   );

   // Line settings
   assign lineSync   = regParCsr[7:0];
   assign crcInhibit = regParCsr[crcInhBit];
   assign secMode    = regParCsr[ssmBit];
   assign decMode    = regParCsr[decModeBit];

   dupRxCsr rxCsr
   (
      .clk        (clk),
      .rstN       (rstN),
      .dupInit    (dupInit),
      .rxCsrWrite (rxCsrWrite),
      .rxDbufRead (rxDbufRead),
      .busLoByte  (busLoByte),
      .busData    (busData),
      .rxValid    (rxValid),
      .rxChar     (rxChar),
      .rxReady    (rxReady),
      .regRxCsr   (regRxCsr),
      .regRxDbuf  (regRxDbuf),
      .rxIntr     (rxIntr)
   );

   // Buffer load also clears transmit done
   dupTxCsr txCsr
   (
      .clk        (clk),
      .rstN       (rstN),
      .busInit    (busInit),
      .txCsrWrite (txCsrWrite),
      .busLoByte  (busLoByte),
      .busData    (busData),
      .txSent     (txSent),
      .txDbufLoad (txDbufWrite),
      .dupInit    (dupInit),
      .sendEn     (sendEn),
      .regTxCsr   (regTxCsr),
      .txIntr     (txIntr)
   );

   dupTxPath txPath
   (
      .clk         (clk),
      .rstN        (rstN),
      .dupInit     (dupInit),
      .txDbufWrite (txDbufWrite),
      .busLoByte   (busLoByte),
      .busData     (busData),
      .sendEn      (sendEn),
      .txValid     (txValid),
      .txChar      (txChar),
      .txSent      (txSent),
      .regTxDbuf   (regTxDbuf),
      .txReady     (txReady)
   );

endmodule

// File: verif/dupRegsTb.sv
//////////////////////////////////////////////////////////////////////
// DUP11 register block testbench
// Host bus and line models, a reference model of the device
// registers, and concurrent checks of every DUT output against it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dupRegsTb;

   import dupPkg::*;

   localparam int clkPeriod  = 100;
   localparam int numSteps   = 6;
   localparam int stepCycles = 200;

   logic                 clk = 1'b0;
   logic                 rstN;
   logic [1:0]           busAddr;
   logic                 busWrite;
   logic                 busRead;
   logic                 busLoByte;
   logic                 busHiByte;
   logic [dataWidth-1:0] busData;
   logic                 busInit;
   logic [regWidth-1:0]  rdData;
   logic                 rdValid;
   logic                 rxIntr;
   logic                 txIntr;
   logic                 rxValid = 1'b0;
   logic [7:0]           rxChar = 8'h00;
   logic                 rxReady;
   logic                 txValid;
   logic [7:0]           txChar;
   logic                 txReady = 1'b0;
   logic [7:0]           lineSync;
   logic                 crcInhibit;
   logic                 secMode;
   logic                 decMode;

   // Line model controls
   logic        rxOffer;
   logic        txStall;
   logic        rxTakeNext = 1'b0;
   logic [31:0] lineRand = '0;
   logic [31:0] laneRand;

   // Reference model state
   logic        mInit;
   logic        mRdValid;
   logic [15:0] mRdData;
   logic [7:0]  mSync;
   logic        mDec;
   logic        mSsm;
   logic        mCrc;
   logic        mRxEn;
   logic        mRxIe;
   logic        mRxDone;
   logic [7:0]  mRxBuf;
   logic        mSend;
   logic        mTxIe;
   logic        mTxDone;
   logic        mTxFull;
   logic [7:0]  mTxChar;
   logic        mRxReady;
   logic        mTxValid;
   logic        wrRxCsr;
   logic        wrPar;
   logic        wrTxCsr;
   logic        wrTxDbuf;

   dupRegs uut (.*);

   always #(clkPeriod / 2) clk = !clk;

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Offset 1 is PARCSR on write
   assign wrRxCsr  = busWrite && (busAddr == selRxCsr);
   assign wrPar    = busWrite && (busAddr == selRxDbuf);
   assign wrTxCsr  = busWrite && (busAddr == selTxCsr);
   assign wrTxDbuf = busWrite && (busAddr == selTxDbuf);

   // Ready when disabled or empty
   assign mRxReady = !mRxEn || !mRxDone;
   assign mTxValid = mTxFull && mSend;

   function automatic logic [15:0] modelRead(input logic [1:0] addr);
      logic [15:0] value;
      value = '0;
      case (addr)
         selRxCsr:
         begin
            value[rxDoneBit] = mRxDone;
            value[rxIeBit]   = mRxIe;
            value[rxEnBit]   = mRxEn;
         end
         selRxDbuf:
            value[7:0] = mRxBuf;
         selTxCsr:
         begin
            value[txDoneBit] = mTxDone;
            value[txIeBit]   = mTxIe;
            value[sendBit]   = mSend;
         end
         default:
            value[7:0] = mTxChar;
      endcase
      return value;
   endfunction

   // Init pulse and read port
   always @(posedge clk)
   begin
      if (!rstN)
      begin
         mInit    <= 1'b0;
         mRdValid <= 1'b0;
      end
      else
      begin
         mInit    <= busInit || (wrTxCsr && busLoByte && busData[dresetBit]);
         mRdValid <= busRead;
      end
      if (busRead)
         mRdData <= modelRead(busAddr);
   end

   // Device registers
   always @(posedge clk)
   begin
      if (!rstN || mInit)
      begin
         mSync   <= 8'h00;
         mDec    <= 1'b0;
         mSsm    <= 1'b0;
         mCrc    <= 1'b0;
         mRxEn   <= 1'b0;
         mRxIe   <= 1'b0;
         mRxDone <= 1'b0;
         mRxBuf  <= 8'h00;
         mSend   <= 1'b0;
         mTxIe   <= 1'b0;
         mTxDone <= 1'b1;
         mTxFull <= 1'b0;
         mTxChar <= 8'h00;
      end
      else
      begin
         // PARCSR, one byte per lane
         if (wrPar && busLoByte)
            mSync <= busData[7:0];
         if (wrPar && busHiByte)
         begin
            mDec <= busData[decModeBit];
            mSsm <= busData[ssmBit];
            mCrc <= busData[crcInhBit];
         end
         // Receiver
         if (wrRxCsr && busLoByte)
         begin
            mRxEn <= busData[rxEnBit];
            mRxIe <= busData[rxIeBit];
         end
         if (rxValid && mRxReady && mRxEn)
         begin
            mRxDone <= 1'b1;
            mRxBuf  <= rxChar;
         end
         else if (busRead && (busAddr == selRxDbuf))
            mRxDone <= 1'b0;
         // Transmitter
         if (wrTxCsr && busLoByte)
         begin
            mSend <= busData[sendBit];
            mTxIe <= busData[txIeBit];
         end
         if (wrTxDbuf)
         begin
            mTxFull <= 1'b1;
            mTxDone <= 1'b0;
            if (busLoByte)
               mTxChar <= busData[7:0];
         end
         else if (mTxValid && txReady)
         begin
            mTxFull <= 1'b0;
            mTxDone <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   task automatic reportMismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] expected);
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   rdValidCheck: assert property (@(posedge clk) disable iff (!rstN) rdValid == mRdValid)
      else reportMismatch("rdValid", 16'($sampled(rdValid)), 16'($sampled(mRdValid)));

   rdDataCheck: assert property (@(posedge clk) disable iff (!rstN)
      rdValid |-> rdData == mRdData)
      else reportMismatch("rdData", $sampled(rdData), $sampled(mRdData));

   rxReadyCheck: assert property (@(posedge clk) disable iff (!rstN) rxReady == mRxReady)
      else reportMismatch("rxReady", 16'($sampled(rxReady)), 16'($sampled(mRxReady)));

   rxIntrCheck: assert property (@(posedge clk) disable iff (!rstN)
      rxIntr == (mRxDone && mRxIe))
      else reportMismatch("rxIntr", 16'($sampled(rxIntr)),
                          16'($sampled(mRxDone && mRxIe)));

   txValidCheck: assert property (@(posedge clk) disable iff (!rstN) txValid == mTxValid)
      else reportMismatch("txValid", 16'($sampled(txValid)), 16'($sampled(mTxValid)));

   txCharCheck: assert property (@(posedge clk) disable iff (!rstN)
      txValid |-> txChar == mTxChar)
      else reportMismatch("txChar", 16'($sampled(txChar)), 16'($sampled(mTxChar)));

   txIntrCheck: assert property (@(posedge clk) disable iff (!rstN)
      txIntr == (mTxDone && mTxIe))
      else reportMismatch("txIntr", 16'($sampled(txIntr)),
                          16'($sampled(mTxDone && mTxIe)));

   lineSyncCheck: assert property (@(posedge clk) disable iff (!rstN) lineSync == mSync)
      else reportMismatch("lineSync", 16'($sampled(lineSync)), 16'($sampled(mSync)));

   // Packed as crcInhibit, secMode, decMode
   lineModeCheck: assert property (@(posedge clk) disable iff (!rstN)
      {crcInhibit, secMode, decMode} == {mCrc, mSsm, mDec})
      else reportMismatch("lineMode", 16'($sampled({crcInhibit, secMode, decMode})),
                          16'($sampled({mCrc, mSsm, mDec})));

   //////////////////////////////////////////////////////////////////////
   // Line models
   //////////////////////////////////////////////////////////////////////

   // Draw at the falling edge, apply after the rising edge
   always @(negedge clk)
   begin
      rxTakeNext = rxValid && rxReady;
      lineRand   = $urandom;
   end

   always @(posedge clk)
   begin
      #1;
      // Ready one cycle in four while stalling
      txReady = !txStall || (lineRand[9:8] == 2'b00);
      if (!rstN)
         rxValid = 1'b0;
      else if (!rxValid || rxTakeNext)
      begin
         rxValid = rxOffer;
         rxChar  = lineRand[7:0];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Host bus tasks
   //////////////////////////////////////////////////////////////////////

   function automatic logic [dataWidth-1:0] randomWord();
      logic [63:0] r;
      r = {$urandom, $urandom};
      return r[dataWidth-1:0];
   endfunction

   function automatic logic [dataWidth-1:0] bitsOf(input int pos);
      return dataWidth'(1) << pos;
   endfunction

   task automatic writeReg(input logic [1:0] addr, input logic [dataWidth-1:0] data,
                           input logic lo, input logic hi);
      @(posedge clk);
      #1;
      busAddr   = addr;
      busData   = data;
      busLoByte = lo;
      busHiByte = hi;
      busWrite  = 1'b1;
      @(posedge clk);
      #1;
      busWrite  = 1'b0;
      busLoByte = 1'b0;
      busHiByte = 1'b0;
   endtask

   task automatic readReg(input logic [1:0] addr);
      @(posedge clk);
      #1;
      busAddr = addr;
      busRead = 1'b1;
      @(posedge clk);
      #1;
      busRead = 1'b0;
   endtask

   // RXDBUF last, its read clears rxDone
   task automatic readAll();
      readReg(selRxCsr);
      readReg(selTxCsr);
      readReg(selTxDbuf);
      readReg(selRxDbuf);
   endtask

   // Back-to-back reads at random offsets
   task automatic readBurst(input int count);
      logic [31:0] r;
      @(posedge clk);
      #1;
      repeat (count)
      begin
         r       = $urandom;
         busAddr = r[1:0];
         busRead = 1'b1;
         @(posedge clk);
         #1;
      end
      busRead = 1'b0;
   endtask

   // Every register away from its reset value, transmit pending
   task automatic loadDeviceState();
      writeReg(selRxDbuf, randomWord(), 1'b1, 1'b1);
      writeReg(selRxCsr, bitsOf(rxEnBit) | bitsOf(rxIeBit), 1'b1, 1'b0);
      @(negedge clk);
      rxOffer = 1'b1;
      while (!rxIntr)
         @(negedge clk);
      rxOffer = 1'b0;
      writeReg(selTxCsr, bitsOf(txIeBit), 1'b1, 1'b0);
      writeReg(selTxDbuf, randomWord(), 1'b1, 1'b0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      void'($urandom(62731));
      rstN      = 1'b0;
      busAddr   = '0;
      busWrite  = 1'b0;
      busRead   = 1'b0;
      busLoByte = 1'b0;
      busHiByte = 1'b0;
      busData   = '0;
      busInit   = 1'b0;
      rxOffer   = 1'b0;
      txStall   = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      rstN = 1'b1;

      // Reset values
      readAll();

      // PARCSR byte lanes
      repeat (12)
      begin
         laneRand = $urandom;
         writeReg(selRxDbuf, randomWord(), laneRand[0], laneRand[1]);
      end

      // Receive with interrupt enabled
      writeReg(selRxCsr, bitsOf(rxEnBit) | bitsOf(rxIeBit), 1'b1, 1'b0);
      @(negedge clk);
      rxOffer = 1'b1;
      repeat (4)
      begin
         @(negedge clk);
         while (!rxIntr)
            @(negedge clk);
         // Next character waits for the buffer read
         repeat (4) @(posedge clk);
         readReg(selRxCsr);
         readReg(selRxDbuf);
      end
      writeReg(selRxCsr, bitsOf(rxEnBit), 1'b1, 1'b0);
      @(negedge clk);
      while (rxReady)
         @(negedge clk);
      readReg(selRxCsr);
      // Receiver off, characters dropped
      writeReg(selRxCsr, '0, 1'b1, 1'b0);
      repeat (10) @(posedge clk);
      readReg(selRxCsr);
      readReg(selRxDbuf);
      @(negedge clk);
      rxOffer = 1'b0;

      // Transmit under line stalls
      @(negedge clk);
      txStall = 1'b1;
      writeReg(selTxCsr, bitsOf(txIeBit), 1'b1, 1'b0);
      writeReg(selTxDbuf, randomWord(), 1'b1, 1'b0);
      repeat (6) @(posedge clk);
      readReg(selTxCsr);
      repeat (6)
      begin
         writeReg(selTxCsr, bitsOf(sendBit) | bitsOf(txIeBit), 1'b1, 1'b0);
         @(negedge clk);
         while (!(txValid && txReady))
            @(negedge clk);
         @(posedge clk);
         readReg(selTxCsr);
         readReg(selTxDbuf);
         // Send off so the next character waits in the buffer
         writeReg(selTxCsr, bitsOf(txIeBit), 1'b1, 1'b0);
         writeReg(selTxDbuf, randomWord(), 1'b1, 1'b0);
         readReg(selTxCsr);
      end
      writeReg(selTxCsr, '0, 1'b1, 1'b0);
      @(negedge clk);
      txStall = 1'b0;

      // Device reset through TXCSR
      loadDeviceState();
      writeReg(selTxCsr, bitsOf(dresetBit), 1'b1, 1'b0);
      repeat (3) @(posedge clk);
      readAll();

      // Host bus init, then send must find nothing pending
      loadDeviceState();
      @(posedge clk);
      #1;
      busInit = 1'b1;
      @(posedge clk);
      #1;
      busInit = 1'b0;
      repeat (3) @(posedge clk);
      readAll();
      writeReg(selTxCsr, bitsOf(sendBit), 1'b1, 1'b0);
      repeat (4) @(posedge clk);
      writeReg(selTxCsr, '0, 1'b1, 1'b0);

      // Read timing
      readBurst(16);
      repeat (2) @(posedge clk);

      $display("Simulation PASSED");
      $finish;
   end

   // Watchdog, stepCycles per test step
   initial
   begin
      #(numSteps * stepCycles * clkPeriod);
      $display("Watchdog expired, tests did not finish within %0d cycles",
               numSteps * stepCycles);
      $display("Simulation FAILED");
      $fatal(1);
   end

endmodule

// File: dupRegs.f
hdl/dupPkg.sv
hdl/dupParCsr.sv
hdl/dupRxCsr.sv
hdl/dupTxCsr.sv
hdl/dupTxPath.sv
hdl/dupBusDecode.sv
hdl/dupRegs.sv
verif/dupRegsTb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the DUP11 register block testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" &&
   verilator --binary --timing --assert --top-module dupRegsTb \
      -f dupRegs.f -o dupRegsSim &&
   ./obj_dir/dupRegsSim ||
   { echo "Build or simulation failed"; exit 1; }
